// ==== verilog/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural register count
`define RV_NREGS 32

`define RV_RESET_PC 32'h8000_0000

`endif

// ==== verilog/rv_pkg.sv ====
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    // rv32 base opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011, // addi
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011, // beq only
        OP_LOAD   = 7'b0000011  // lw only
    } opcode_e;

    // decoder output, consumed by regfile read and execute
    typedef struct packed {
        opcode_e                      opcode;
        logic [2:0]                   funct3;
        logic [$clog2(`RV_NREGS)-1:0] rs1_addr;
        logic [$clog2(`RV_NREGS)-1:0] rs2_addr;
        logic [$clog2(`RV_NREGS)-1:0] rd_addr;
        logic [`RV_XLEN-1:0]          imm;          // sign extended per format
        logic                         reg_write_en;
    } dec_t;

    // register write port, also the retire trace
    typedef struct packed {
        logic                         wen;
        logic [$clog2(`RV_NREGS)-1:0] addr;
        logic [`RV_XLEN-1:0]          data;
    } wb_t;

endpackage

`default_nettype wire

// ==== verilog/mux_key.sv ====
`timescale 1ns/100ps
`default_nettype none

module mux_key #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    input  wire logic [KEY_LEN-1:0]                   key,
    input  wire logic [DATA_LEN-1:0]                  default_out,
    input  wire logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut,
    output logic [DATA_LEN-1:0]                       out
);

    localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

    // first entry of the list sits in the top bits
    always_comb begin
        logic [PAIR_LEN-1:0] pair;
        out = default_out;
        for (int i = 0; i < NR_KEY; i++) begin
            pair = lut[i*PAIR_LEN +: PAIR_LEN];
            if (pair[PAIR_LEN-1 -: KEY_LEN] == key) begin
                out = pair[DATA_LEN-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_idu.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_idu import rv_pkg::*; (
    input  wire logic [31:0] inst,
    output dec_t             dec
);

    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    opcode_e     opcode;
    logic [2:0]  funct3;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        dec          = '0;
        dec.opcode   = opcode;
        dec.funct3   = funct3;
        dec.rs1_addr = inst[19:15];
        dec.rs2_addr = inst[24:20];
        dec.rd_addr  = inst[11:7];

        case (opcode)
            OP_IMM: begin
                dec.imm          = imm_i;
                dec.reg_write_en = (funct3 == 3'b000); // addi
            end
            OP_LUI: begin
                dec.imm          = imm_u;
                dec.reg_write_en = 1'b1;
            end
            OP_AUIPC: begin
                dec.imm          = imm_u;
                dec.reg_write_en = 1'b1;
            end
            OP_JAL: begin
                dec.imm          = imm_j;
                dec.reg_write_en = 1'b1;
            end
            OP_JALR: begin
                dec.imm          = imm_i;
                dec.reg_write_en = (funct3 == 3'b000);
            end
            OP_BRANCH: begin
                dec.imm          = imm_b; // no write for branches
            end
            OP_LOAD: begin
                dec.imm          = imm_i;
                dec.reg_write_en = (funct3 == 3'b010); // lw
            end
            default: begin
                // unsupported, no write and pc+4 downstream
                dec.imm          = '0;
                dec.reg_write_en = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module rv_regfile import rv_pkg::*; (
    input  wire logic                         clock,
    input  wire logic                         arst_n,
    input  wire logic [$clog2(`RV_NREGS)-1:0] rs1_addr,
    input  wire logic [$clog2(`RV_NREGS)-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]               rs1_data,
    output logic [`RV_XLEN-1:0]               rs2_data,
    input  wb_t                               wb
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wen && (wb.addr != '0)) begin // x0 stays zero
            regs[wb.addr] <= wb.data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// ==== verilog/rv_exu.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_exu import rv_pkg::*; (
    input  dec_t              dec,
    input  wire logic [31:0]  rs1_data,
    input  wire logic [31:0]  rs2_data,
    input  wire logic [31:0]  pc,
    input  wire logic [31:0]  mem_rdata,
    output logic [31:0]       mem_addr,
    output wb_t               wb,
    output logic [31:0]       next_pc
);

    logic [31:0] alu_a;
    logic [31:0] alu_sum;
    logic [31:0] result;
    logic [31:0] pc_plus4;
    logic [31:0] pc_target;    // jal and taken beq
    logic [31:0] jalr_target;
    logic [31:0] jalr_next;
    logic [31:0] branch_next;
    logic        branch_taken;

    mux_key #(.NR_KEY(3), .KEY_LEN(7), .DATA_LEN(32)) alu_a_select (
        .key         (dec.opcode),
        .default_out (rs1_data),
        .lut         ({OP_AUIPC, pc,
                       OP_LUI,   32'b0,
                       OP_JAL,   pc}),
        .out         (alu_a)
    );

    assign alu_sum  = alu_a + dec.imm;
    assign mem_addr = alu_sum; // lw address

    assign pc_plus4    = pc + 32'd4;
    assign pc_target   = pc + dec.imm;
    assign jalr_target = (rs1_data + dec.imm) & ~32'h1;

    // only funct3 000 is a real jalr or beq
    assign jalr_next    = (dec.funct3 == 3'b000) ? jalr_target : pc_plus4;
    assign branch_taken = (dec.funct3 == 3'b000) && (rs1_data == rs2_data);
    assign branch_next  = branch_taken ? pc_target : pc_plus4;

    mux_key #(.NR_KEY(3), .KEY_LEN(7), .DATA_LEN(32)) result_select (
        .key         (dec.opcode),
        .default_out (alu_sum),
        .lut         ({OP_JAL,  pc_plus4,
                       OP_JALR, pc_plus4,
                       OP_LOAD, mem_rdata}),
        .out         (result)
    );

    mux_key #(.NR_KEY(3), .KEY_LEN(7), .DATA_LEN(32)) next_pc_select (
        .key         (dec.opcode),
        .default_out (pc_plus4),
        .lut         ({OP_JAL,    pc_target,
                       OP_JALR,   jalr_next,
                       OP_BRANCH, branch_next}),
        .out         (next_pc)
    );

    assign wb = '{wen: dec.reg_write_en, addr: dec.rd_addr, data: result};

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module rv_core import rv_pkg::*; (
    input  wire logic                clock,
    input  wire logic                arst_n,
    output logic [`RV_XLEN-1:0]      inst_addr,
    input  wire logic [`RV_XLEN-1:0] inst,
    output logic [`RV_XLEN-1:0]      mem_addr,
    input  wire logic [`RV_XLEN-1:0] mem_rdata,
    output wb_t                      wb
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    dec_t                dec;
    wb_t                 wb_exu;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= next_pc; // one instruction per edge
        end
    end

    assign inst_addr = pc;

    rv_idu rv_idu_inst (
        .inst (inst),
        .dec  (dec)
    );

    rv_regfile rv_regfile_inst (
        .clock    (clock),
        .arst_n   (arst_n),
        .rs1_addr (dec.rs1_addr),
        .rs2_addr (dec.rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    rv_exu rv_exu_inst (
        .dec       (dec),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .pc        (pc),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .wb        (wb_exu),
        .next_pc   (next_pc)
    );

    // no retire while held in reset
    assign wb = '{wen: wb_exu.wen & arst_n, addr: wb_exu.addr, data: wb_exu.data};

endmodule

`default_nettype wire

// ==== testbench/tb_rv_model.svh ====
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// data memory word, every address bit matters
function automatic logic [31:0] dmem_word(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
endfunction

// one retired instruction of the model, updates ref_pc and ref_regs
function automatic void rv_ref_step(input logic [31:0] ins, output wb_t exp_wb,
                                    output logic is_load, output logic [31:0] exp_maddr);
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic [31:0] nxt;
    f3 = ins[14:12];
    rd = ins[11:7];
    rs1v = ref_regs[ins[19:15]];
    rs2v = ref_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    exp_wb = '0;
    exp_wb.addr = rd;
    is_load = 1'b0;
    exp_maddr = '0;
    nxt = ref_pc + 32'd4;
    case (ins[6:0])
        7'b0010011: if (f3 == 3'b000) exp_wb = '{wen: 1'b1, addr: rd, data: rs1v + imm_i};
        7'b0110111: exp_wb = '{wen: 1'b1, addr: rd, data: imm_u};
        7'b0010111: exp_wb = '{wen: 1'b1, addr: rd, data: ref_pc + imm_u};
        7'b1101111: begin
            exp_wb = '{wen: 1'b1, addr: rd, data: ref_pc + 32'd4};
            nxt = ref_pc + imm_j;
        end
        7'b1100111: if (f3 == 3'b000) begin
            exp_wb = '{wen: 1'b1, addr: rd, data: ref_pc + 32'd4};
            nxt = (rs1v + imm_i) & ~32'h1;
        end
        7'b1100011: if (f3 == 3'b000 && rs1v == rs2v) nxt = ref_pc + imm_b;
        7'b0000011: if (f3 == 3'b010) begin
            is_load = 1'b1;
            exp_maddr = rs1v + imm_i;
            exp_wb = '{wen: 1'b1, addr: rd, data: dmem_word(rs1v + imm_i)};
        end
        default: ; // outside the subset
    endcase
    if (exp_wb.wen && rd != 5'd0) ref_regs[rd] = exp_wb.data;
    ref_pc = nxt;
endfunction

function automatic int rnd(input int m);
    return ($random(seed) & 32'h7fff_ffff) % m;
endfunction

// forward-only control flow so every program reaches its end
task automatic gen_random_prog(input int n);
    int left;
    int off;
    int t;
    int reach; // furthest jump target so far
    logic [4:0] rd;
    logic [4:0] rb;
    prog.delete();
    reach = 0;
    while (prog.size() < n) begin
        left = n - prog.size();
        off = 1 + rnd(left < 8 ? left : 8);
        rd = 5'(rnd(32));
        case (rnd(10))
            0, 1, 9: prog.push_back(enc_i(12'(rnd(4096)), 5'(rnd(8)), 3'b000, rd, 7'b0010011));
            2: prog.push_back(enc_u(20'(rnd(1 << 20)), rd, 7'b0110111));
            3: prog.push_back(enc_u(20'(rnd(1 << 20)), rd, 7'b0010111));
            4: begin
                if (prog.size() + off > reach) reach = prog.size() + off;
                prog.push_back(enc_j(21'(off * 4), rd));
            end
            5: begin
                if (prog.size() + off > reach) reach = prog.size() + off;
                prog.push_back(enc_b(13'(off * 4), 5'(rnd(3)), 5'(rnd(3))));
            end
            6: prog.push_back(enc_i(12'(rnd(4096)), 5'(rnd(32)), 3'b010, rd, 7'b0000011));
            7: prog.push_back({25'(rnd(1 << 25)), rnd(2) == 0 ? 7'b0110011 : 7'b0001111});
            default: begin
                // no jump may land past the lui of a jalr sequence
                if (left >= 4 && reach <= prog.size()) begin
                    rb = 5'(1 + rnd(31));
                    t = prog.size() + 3 + rnd(left - 3 < 6 ? left - 3 : 6);
                    reach = t;
                    prog.push_back(enc_u(20'h80000, rb, 7'b0110111));
                    prog.push_back(enc_i(12'(t * 4 - 1), rb, 3'b000, rb, 7'b0010011));
                    prog.push_back(enc_i(12'd2, rb, 3'b000, rd, 7'b1100111)); // odd sum
                end else begin
                    prog.push_back(enc_i(12'd1, 5'd0, 3'b000, rd, 7'b0010011));
                end
            end
        endcase
    end
endtask

`endif

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module tb_rv_core import rv_pkg::*;;

    logic        clock;
    logic        arst_n = 1'b0;
    logic [31:0] inst_addr;
    logic [31:0] inst;
    logic [31:0] mem_addr;
    logic [31:0] mem_rdata;
    wb_t         wb;

    logic [31:0] imem [0:511];
    logic [31:0] imem_idx;
    logic [31:0] prog [$];
    logic [31:0] ref_pc;
    logic [31:0] ref_regs [32];
    logic [31:0] halt_pc;
    logic        checking = 1'b0;
    integer      seed = 32'hb1c8_8adc;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    `include "tb_rv_model.svh"

    rv_core rv_core_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .inst_addr (inst_addr),
        .inst      (inst),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .wb        (wb)
    );

    assign imem_idx  = (inst_addr - `RV_RESET_PC) >> 2;
    assign inst      = (imem_idx < 32'd512) ? imem[imem_idx[8:0]] : 32'h0;
    assign mem_rdata = dmem_word(mem_addr); // same-cycle answer

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // compare at the falling edge, where all combinational outputs are settled
    always @(negedge clock) begin
        wb_t         exp_wb;
        logic        is_load;
        logic [31:0] exp_maddr;
        if (!arst_n) begin
            check_val("inst_addr", inst_addr, `RV_RESET_PC);
            check_val("wb.wen", {31'b0, wb.wen}, 32'd0);
        end else if (checking) begin
            check_val("inst_addr", inst_addr, ref_pc);
            rv_ref_step(inst, exp_wb, is_load, exp_maddr);
            check_val("wb.wen", {31'b0, wb.wen}, {31'b0, exp_wb.wen});
            if (exp_wb.wen) begin
                check_val("wb.addr", {27'b0, wb.addr}, {27'b0, exp_wb.addr});
                check_val("wb.data", wb.data, exp_wb.data);
            end
            if (is_load) check_val("mem_addr", mem_addr, exp_maddr);
        end
    end

    task automatic run_program(input string name);
        int cycles;
        int err_before;
        err_before = errors;
        @(posedge clock);
        arst_n <= 1'b0;
        checking <= 1'b0;
        for (int i = 0; i < 512; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : enc_j(21'd0, 5'd0); // halt loop
        end
        repeat (8) @(posedge clock);
        ref_pc = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        halt_pc = `RV_RESET_PC + 32'(prog.size() * 4);
        arst_n <= 1'b1;
        checking <= 1'b1;
        cycles = 0;
        while (ref_pc != halt_pc && cycles < 2000) begin
            @(posedge clock);
            cycles++;
        end
        @(posedge clock); // one more cycle to check the last next pc
        checking <= 1'b0;
        if (ref_pc != halt_pc) begin
            $display("timeout: program %s never reached its last instruction", name);
            $display(">>> FAIL");
            $finish;
        end else begin
            tests_run++;
            if (errors != err_before) tests_failed++;
            $display("test %s: %s", name, errors == err_before ? "ok" : "failed");
        end
    endtask

    initial begin
        prog = '{32'h0, enc_i(12'd1, 5'd0, 3'b000, 5'd1, 7'b0010011)};
        run_program("reset");
        prog = '{enc_i(12'h123, 5'd0, 3'b000, 5'd1, 7'b0010011),
                 enc_u(20'habcde, 5'd2, 7'b0110111),
                 enc_u(20'h00010, 5'd3, 7'b0010111),
                 enc_i(12'd5, 5'd0, 3'b000, 5'd0, 7'b0010011),
                 enc_i(12'd0, 5'd0, 3'b000, 5'd4, 7'b0010011)};
        run_program("arith");
        prog = '{enc_j(21'd8, 5'd5), 32'h0,
                 enc_u(20'h80000, 5'd6, 7'b0110111),
                 enc_i(12'h01d, 5'd6, 3'b000, 5'd6, 7'b0010011),
                 enc_i(12'd0, 5'd6, 3'b000, 5'd7, 7'b1100111), 32'h0, 32'h0,
                 enc_i(12'd0, 5'd5, 3'b000, 5'd8, 7'b0010011)};
        run_program("jumps");
        prog = '{enc_i(12'd7, 5'd0, 3'b000, 5'd1, 7'b0010011),
                 enc_i(12'd7, 5'd0, 3'b000, 5'd2, 7'b0010011),
                 enc_b(13'd8, 5'd2, 5'd1), 32'h0,
                 enc_b(13'd8, 5'd0, 5'd1),
                 enc_i(12'd1, 5'd0, 3'b000, 5'd3, 7'b0010011)};
        run_program("branch");
        prog = '{enc_u(20'h12345, 5'd1, 7'b0110111),
                 enc_i(12'h7f0, 5'd1, 3'b010, 5'd2, 7'b0000011),
                 enc_i(12'hffc, 5'd0, 3'b010, 5'd3, 7'b0000011)};
        run_program("load");
        gen_random_prog(300);
        run_program("random");
        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
+incdir+testbench
verilog/rv_pkg.sv
verilog/mux_key.sv
verilog/rv_idu.sv
verilog/rv_regfile.sv
verilog/rv_exu.sv
verilog/rv_core.sv
testbench/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -f verilog.f --top-module tb_rv_core

output=$(./obj_dir/Vtb_rv_core)
echo "$output"

if grep -qx '>>> PASS' <<< "$output"; then
    exit 0
else
    exit 1
fi
